// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_lsu
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/ldq.sv
`timescale 1ns/1ns
`default_nettype none

module ldq #(
  parameter int LDQ_SIZE  = 8,
  parameter int TAG_LINES = 4
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  input  logic                           i_disp_valid,
  input  lsu_pkg::rob_id_t               i_disp_rob_id,
  input  lsu_pkg::vaddr_t                i_disp_vaddr,
  output logic                           o_disp_credit,

  output logic                           o_iss_valid,
  output lsu_pkg::rob_id_t               o_iss_rob_id,
  output lsu_pkg::vaddr_t                o_iss_vaddr,
  output logic [$clog2(LDQ_SIZE)-1:0]    o_iss_index,

  input  logic                           i_ex1_valid,
  input  logic [$clog2(LDQ_SIZE)-1:0]    i_ex1_index,
  input  logic                           i_ex1_tlb_haz,
  input  logic                           i_ex2_valid,
  input  logic [$clog2(LDQ_SIZE)-1:0]    i_ex2_index,
  input  logic                           i_ex2_miss,

  input  logic [lsu_pkg::PAGE_NUM-1:0]   i_tlb_page_valid,
  input  logic                           i_refill_valid,
  input  lsu_pkg::vaddr_t                i_refill_vaddr,

  output logic                           o_done_valid,
  output lsu_pkg::rob_id_t               o_done_rob_id,
  output lsu_pkg::vaddr_t                o_done_vaddr
);

  localparam int IDX_W  = $clog2(LDQ_SIZE);
  localparam int LINE_W = $clog2(TAG_LINES);

  lsu_pkg::ldq_state_t r_state  [LDQ_SIZE];
  lsu_pkg::rob_id_t    r_rob_id [LDQ_SIZE];
  lsu_pkg::vaddr_t     r_vaddr  [LDQ_SIZE];

  logic [LDQ_SIZE-1:0] w_free;
  logic [LDQ_SIZE-1:0] w_wait;
  logic [LDQ_SIZE-1:0] w_done;
  logic [LDQ_SIZE-1:0] w_page_ok;
  logic [LDQ_SIZE-1:0] w_line_hit;
  logic [LDQ_SIZE-1:0] w_alloc_oh;
  logic [LDQ_SIZE-1:0] w_iss_oh;
  logic [LDQ_SIZE-1:0] w_done_oh;

  logic                w_free_any;
  logic                w_alloc;
  logic [IDX_W-1:0]    w_alloc_idx;
  logic [IDX_W-1:0]    w_idx_tbl [LDQ_SIZE];
  logic [LINE_W-1:0]   w_refill_line;

  lsu_pkg::load_req_t  w_iss_tbl [LDQ_SIZE];
  lsu_pkg::load_req_t  w_iss_req;
  lsu_pkg::done_rpt_t  w_done_tbl [LDQ_SIZE];
  lsu_pkg::done_rpt_t  w_done_rpt;

  assign w_refill_line = i_refill_vaddr[lsu_pkg::LINE_OFF_W +: LINE_W];

  // per-entry status vectors and pick payloads
  always_comb begin
    for (int i = 0; i < LDQ_SIZE; i++) begin
      w_free[i]            = r_state[i] == lsu_pkg::FREE;
      w_wait[i]            = r_state[i] == lsu_pkg::WAIT_ISSUE;
      w_done[i]            = r_state[i] == lsu_pkg::DONE;
      w_page_ok[i]         = i_tlb_page_valid[r_vaddr[i][lsu_pkg::PAGE_LSB +: lsu_pkg::PAGE_W]];
      w_line_hit[i]        = i_refill_valid &&
                             r_vaddr[i][lsu_pkg::LINE_OFF_W +: LINE_W] == w_refill_line;
      w_idx_tbl[i]         = IDX_W'(i);
      w_iss_tbl[i].rob_id  = r_rob_id[i];
      w_iss_tbl[i].vaddr   = r_vaddr[i];
      w_iss_tbl[i].index   = (lsu_pkg::LDQ_IDX_MAX_W)'(i);
      w_done_tbl[i].rob_id = r_rob_id[i];
      w_done_tbl[i].vaddr  = r_vaddr[i];
    end
  end

  // ==================================================
  // allocation, issue and done picks
  // ==================================================
  ldq_pick #(.WIDTH(LDQ_SIZE), .T(logic [IDX_W-1:0])) u_alloc_pick (
    .i_req   (w_free),
    .i_data  (w_idx_tbl),
    .o_valid (w_free_any),
    .o_oh    (w_alloc_oh),
    .o_data  (w_alloc_idx)
  );

  ldq_pick #(.WIDTH(LDQ_SIZE), .T(lsu_pkg::load_req_t)) u_iss_pick (
    .i_req   (w_wait),
    .i_data  (w_iss_tbl),
    .o_valid (o_iss_valid),
    .o_oh    (w_iss_oh),
    .o_data  (w_iss_req)
  );

  ldq_pick #(.WIDTH(LDQ_SIZE), .T(lsu_pkg::done_rpt_t)) u_done_pick (
    .i_req   (w_done),
    .i_data  (w_done_tbl),
    .o_valid (o_done_valid),
    .o_oh    (w_done_oh),
    .o_data  (w_done_rpt)
  );

  assign w_alloc = i_disp_valid & w_free_any; // credits keep a free entry around

  assign o_iss_rob_id  = w_iss_req.rob_id;
  assign o_iss_vaddr   = w_iss_req.vaddr;
  assign o_iss_index   = w_iss_req.index[IDX_W-1:0];
  assign o_done_rob_id = w_done_rpt.rob_id;
  assign o_done_vaddr  = w_done_rpt.vaddr;
  assign o_disp_credit = o_done_valid;       // entry frees on the report edge

  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_rob_id[w_alloc_idx] <= i_disp_rob_id;
      r_vaddr[w_alloc_idx]  <= i_disp_vaddr;
    end
  end

  // ==================================================
  // entry state machine
  // ==================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < LDQ_SIZE; i++) begin
        r_state[i] <= lsu_pkg::FREE;
      end
    end else begin
      for (int i = 0; i < LDQ_SIZE; i++) begin
        case (r_state[i])
          lsu_pkg::FREE: begin
            if (w_alloc && w_alloc_oh[i]) begin
              r_state[i] <= lsu_pkg::WAIT_ISSUE;
            end
          end
          lsu_pkg::WAIT_ISSUE: begin
            if (w_iss_oh[i]) begin
              r_state[i] <= lsu_pkg::RUN;  // pipe never stalls
            end
          end
          lsu_pkg::RUN: begin
            if (i_ex1_valid && i_ex1_index == IDX_W'(i) && i_ex1_tlb_haz) begin
              r_state[i] <= lsu_pkg::TLB_HAZ;
            end else if (i_ex2_valid && i_ex2_index == IDX_W'(i)) begin
              r_state[i] <= i_ex2_miss ? lsu_pkg::MISS_HAZ : lsu_pkg::DONE;
            end
          end
          lsu_pkg::TLB_HAZ: begin
            if (w_page_ok[i]) begin
              r_state[i] <= lsu_pkg::WAIT_ISSUE;
            end
          end
          lsu_pkg::MISS_HAZ: begin
            // any refill of the line wakes it, tag checked on replay
            if (w_line_hit[i]) begin
              r_state[i] <= lsu_pkg::WAIT_ISSUE;
            end
          end
          lsu_pkg::DONE: begin
            if (w_done_oh[i]) begin
              r_state[i] <= lsu_pkg::FREE;
            end
          end
          default: r_state[i] <= lsu_pkg::FREE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ldq_pick.sv
`timescale 1ns/1ns
`default_nettype none

module ldq_pick #(
  parameter int  WIDTH = 8,
  parameter type T     = logic
) (
  input  logic [WIDTH-1:0] i_req,
  input  T                 i_data [WIDTH],
  output logic             o_valid,
  output logic [WIDTH-1:0] o_oh,
  output T                 o_data
);

  assign o_valid = |i_req;
  assign o_oh    = i_req & (~i_req + WIDTH'(1)); // lowest set bit

  // one-hot, so OR of the selected words is the payload
  always_comb begin
    o_data = T'(0);
    for (int i = 0; i < WIDTH; i++) begin
      if (o_oh[i]) begin
        o_data = T'(o_data | i_data[i]);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/load_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module load_pipe #(
  parameter int LDQ_SIZE  = 8,
  parameter int TAG_LINES = 4
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic                          i_iss_valid,
  input  lsu_pkg::vaddr_t               i_iss_vaddr,
  input  logic [$clog2(LDQ_SIZE)-1:0]   i_iss_index,

  input  logic [lsu_pkg::PAGE_NUM-1:0]  i_tlb_page_valid,
  input  logic                          i_refill_valid,
  input  lsu_pkg::vaddr_t               i_refill_vaddr,

  output logic                          o_ex1_valid,
  output logic [$clog2(LDQ_SIZE)-1:0]   o_ex1_index,
  output logic                          o_ex1_tlb_haz,
  output logic                          o_ex2_valid,
  output logic [$clog2(LDQ_SIZE)-1:0]   o_ex2_index,
  output logic                          o_ex2_miss
);

  localparam int IDX_W  = $clog2(LDQ_SIZE);
  localparam int LINE_W = $clog2(TAG_LINES);
  localparam int TAG_LSB = lsu_pkg::LINE_OFF_W + LINE_W;
  localparam int TAG_W  = lsu_pkg::VADDR_W - TAG_LSB;

  logic                 r_ex1_valid;
  lsu_pkg::vaddr_t      r_ex1_vaddr;
  logic [IDX_W-1:0]     r_ex1_index;
  logic                 r_ex2_valid;
  lsu_pkg::vaddr_t      r_ex2_vaddr;
  logic [IDX_W-1:0]     r_ex2_index;

  logic [TAG_LINES-1:0] r_tag_valid;
  logic [TAG_W-1:0]     r_tag [TAG_LINES];

  logic                 w_ex1_haz;
  logic [LINE_W-1:0]    w_ex2_line;
  logic [TAG_W-1:0]     w_ex2_tag;
  logic [LINE_W-1:0]    w_refill_line;
  logic [TAG_W-1:0]     w_refill_tag;
  logic                 w_refill_byp;
  logic                 w_ex2_hit;

  // ==================================================
  // EX1 page check
  // ==================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_iss_valid;
      r_ex2_valid <= r_ex1_valid & ~w_ex1_haz; // hazards stop here
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_vaddr <= i_iss_vaddr;
    r_ex1_index <= i_iss_index;
    r_ex2_vaddr <= r_ex1_vaddr;
    r_ex2_index <= r_ex1_index;
  end

  assign w_ex1_haz = ~i_tlb_page_valid[r_ex1_vaddr[lsu_pkg::PAGE_LSB +: lsu_pkg::PAGE_W]];

  assign o_ex1_valid   = r_ex1_valid;
  assign o_ex1_index   = r_ex1_index;
  assign o_ex1_tlb_haz = w_ex1_haz;

  // ==================================================
  // EX2 tag lookup
  // ==================================================
  assign w_ex2_line    = r_ex2_vaddr[lsu_pkg::LINE_OFF_W +: LINE_W];
  assign w_ex2_tag     = r_ex2_vaddr[TAG_LSB +: TAG_W];
  assign w_refill_line = i_refill_vaddr[lsu_pkg::LINE_OFF_W +: LINE_W];
  assign w_refill_tag  = i_refill_vaddr[TAG_LSB +: TAG_W];

  // refill to the same line this cycle wins over the array
  assign w_refill_byp = i_refill_valid && w_refill_line == w_ex2_line;
  assign w_ex2_hit    = w_refill_byp ? (w_refill_tag == w_ex2_tag) :
                        (r_tag_valid[w_ex2_line] && r_tag[w_ex2_line] == w_ex2_tag);

  assign o_ex2_valid = r_ex2_valid;
  assign o_ex2_index = r_ex2_index;
  assign o_ex2_miss  = ~w_ex2_hit;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tag_valid <= '0;
    end else if (i_refill_valid) begin
      r_tag_valid[w_refill_line] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_refill_valid) begin
      r_tag[w_refill_line] <= w_refill_tag;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // ==================================================
  // address layout
  // ==================================================
  localparam int VADDR_W    = 16;
  localparam int PAGE_LSB   = 12;                   // page number is [15:12]
  localparam int PAGE_W     = VADDR_W - PAGE_LSB;
  localparam int PAGE_NUM   = 1 << PAGE_W;
  localparam int LINE_OFF_W = 4;                    // byte offset in line

  localparam int ROB_ID_W = 6;

  // widest queue index the issue payload can carry
  localparam int LDQ_IDX_MAX_W = 4;

  typedef logic [VADDR_W-1:0]  vaddr_t;
  typedef logic [ROB_ID_W-1:0] rob_id_t;

  typedef enum logic [2:0] {
    FREE       = 3'd0,
    WAIT_ISSUE = 3'd1,  // new or woken for replay
    RUN        = 3'd2,  // in the pipe
    TLB_HAZ    = 3'd3,
    MISS_HAZ   = 3'd4,
    DONE       = 3'd5
  } ldq_state_t;

  typedef struct packed {
    rob_id_t                  rob_id;
    vaddr_t                   vaddr;
    logic [LDQ_IDX_MAX_W-1:0] index;
  } load_req_t;

  typedef struct packed {
    rob_id_t rob_id;
    vaddr_t  vaddr;
  } done_rpt_t;

endpackage

`default_nettype wire

// File: rtl/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
  parameter int LDQ_SIZE  = 8,
  parameter int TAG_LINES = 4
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,

  input  logic                          i_disp_valid,
  input  lsu_pkg::rob_id_t              i_disp_rob_id,
  input  lsu_pkg::vaddr_t               i_disp_vaddr,
  output logic                          o_disp_credit,

  input  logic [lsu_pkg::PAGE_NUM-1:0]  i_tlb_page_valid,
  input  logic                          i_refill_valid,
  input  lsu_pkg::vaddr_t               i_refill_vaddr,

  output logic                          o_done_valid,
  output lsu_pkg::rob_id_t              o_done_rob_id,
  output lsu_pkg::vaddr_t               o_done_vaddr
);

  localparam int IDX_W = $clog2(LDQ_SIZE);

  // queue to pipe
  logic             w_iss_valid;
  lsu_pkg::vaddr_t  w_iss_vaddr;
  logic [IDX_W-1:0] w_iss_index;

  // pipe results back to the queue
  logic             w_ex1_valid;
  logic [IDX_W-1:0] w_ex1_index;
  logic             w_ex1_tlb_haz;
  logic             w_ex2_valid;
  logic [IDX_W-1:0] w_ex2_index;
  logic             w_ex2_miss;

  ldq #(.LDQ_SIZE(LDQ_SIZE), .TAG_LINES(TAG_LINES)) u_ldq (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_disp_valid     (i_disp_valid),
    .i_disp_rob_id    (i_disp_rob_id),
    .i_disp_vaddr     (i_disp_vaddr),
    .o_disp_credit    (o_disp_credit),
    .o_iss_valid      (w_iss_valid),
    .o_iss_rob_id     (),
    .o_iss_vaddr      (w_iss_vaddr),
    .o_iss_index      (w_iss_index),
    .i_ex1_valid      (w_ex1_valid),
    .i_ex1_index      (w_ex1_index),
    .i_ex1_tlb_haz    (w_ex1_tlb_haz),
    .i_ex2_valid      (w_ex2_valid),
    .i_ex2_index      (w_ex2_index),
    .i_ex2_miss       (w_ex2_miss),
    .i_tlb_page_valid (i_tlb_page_valid),
    .i_refill_valid   (i_refill_valid),
    .i_refill_vaddr   (i_refill_vaddr),
    .o_done_valid     (o_done_valid),
    .o_done_rob_id    (o_done_rob_id),
    .o_done_vaddr     (o_done_vaddr)
  );

  // rob id rides along in the queue only, pipe tracks the index
  load_pipe #(.LDQ_SIZE(LDQ_SIZE), .TAG_LINES(TAG_LINES)) u_load_pipe (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_iss_valid      (w_iss_valid),
    .i_iss_vaddr      (w_iss_vaddr),
    .i_iss_index      (w_iss_index),
    .i_tlb_page_valid (i_tlb_page_valid),
    .i_refill_valid   (i_refill_valid),
    .i_refill_vaddr   (i_refill_vaddr),
    .o_ex1_valid      (w_ex1_valid),
    .o_ex1_index      (w_ex1_index),
    .o_ex1_tlb_haz    (w_ex1_tlb_haz),
    .o_ex2_valid      (w_ex2_valid),
    .o_ex2_index      (w_ex2_index),
    .o_ex2_miss       (w_ex2_miss)
  );

endmodule

`default_nettype wire

// File: verif/lsu_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_asserts #(
  parameter int LDQ_SIZE = 8
) (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic                i_disp_valid,
  input logic                i_disp_credit,
  input logic                i_done_valid,
  input logic [LDQ_SIZE-1:0] i_free_vec,
  input logic [LDQ_SIZE-1:0] i_done_vec,
  input logic [LDQ_SIZE-1:0] i_done_oh
);

  // the reported entry is the one handed back
  a_credit_frees_entry: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_credit |=> |(i_free_vec & $past(i_done_oh)))
    else $error("credit pulse did not free the reported entry");

  a_done_lowest: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done_valid |-> $onehot(i_done_oh) && (i_done_oh & i_done_vec) == i_done_oh &&
                     ((i_done_oh - 1'b1) & i_done_vec) == '0)
    else $error("done report is not the lowest DONE entry");

  // dispatcher must never run ahead of its credits
  a_alloc_needs_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> |i_free_vec)
    else $error("dispatch accepted with no FREE entry");

endmodule

bind ldq lsu_asserts #(.LDQ_SIZE(LDQ_SIZE)) u_lsu_asserts (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_disp_valid  (i_disp_valid),
  .i_disp_credit (o_disp_credit),
  .i_done_valid  (o_done_valid),
  .i_free_vec    (w_free),
  .i_done_vec    (w_done),
  .i_done_oh     (w_done_oh)
);

`default_nettype wire

// File: verif/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 16
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset_n = 1'b1;  // release off the edge
  end

endmodule

`default_nettype wire

// File: verif/tb_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsu;

  localparam int LDQ_SIZE       = 8;
  localparam int TAG_LINES      = 4;
  localparam int LINE_W         = $clog2(TAG_LINES);
  localparam int TAG_LSB        = lsu_pkg::LINE_OFF_W + LINE_W;
  localparam int TAG_W          = lsu_pkg::VADDR_W - TAG_LSB;
  localparam int ROB_IDS        = 1 << lsu_pkg::ROB_ID_W;
  localparam int TIMEOUT_CYCLES = 4000;  // about 4x the phases added up

  logic                         clk;
  logic                         reset_n;
  logic                         disp_valid;
  lsu_pkg::rob_id_t             disp_rob_id;
  lsu_pkg::vaddr_t              disp_vaddr;
  logic                         disp_credit;
  logic [lsu_pkg::PAGE_NUM-1:0] tlb_page_valid;
  logic                         refill_valid;
  lsu_pkg::vaddr_t              refill_vaddr;
  logic                         done_valid;
  lsu_pkg::rob_id_t             done_rob_id;
  lsu_pkg::vaddr_t              done_vaddr;

  // driver side: page map and tag line model, dispatch record
  logic [lsu_pkg::PAGE_NUM-1:0] page_model;
  logic [TAG_W-1:0]             tag_model [TAG_LINES];
  logic [TAG_LINES-1:0]         tag_valid_model;
  lsu_pkg::vaddr_t              sent_vaddr [ROB_IDS];
  int                           sent_cnt [ROB_IDS];
  int                           next_rob;
  int                           seed = 33656;

  // monitor side
  int                           rpt_cnt [ROB_IDS];
  int                           credits;
  int                           credit_total;
  int                           done_count;
  lsu_pkg::rob_id_t             last_done_rob;
  int                           cycle_count = 0;

  tb_clkgen #(.PERIOD_NS(4), .RESET_CYCLES(16)) u_clkgen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  lsu_top #(.LDQ_SIZE(LDQ_SIZE), .TAG_LINES(TAG_LINES)) DUT (
    .i_clk            (clk),
    .i_reset_n        (reset_n),
    .i_disp_valid     (disp_valid),
    .i_disp_rob_id    (disp_rob_id),
    .i_disp_vaddr     (disp_vaddr),
    .o_disp_credit    (disp_credit),
    .i_tlb_page_valid (tlb_page_valid),
    .i_refill_valid   (refill_valid),
    .i_refill_vaddr   (refill_vaddr),
    .o_done_valid     (done_valid),
    .o_done_rob_id    (done_rob_id),
    .o_done_vaddr     (done_vaddr)
  );

  // ==================================================
  // reference model and compare tasks
  // ==================================================
  function automatic lsu_pkg::vaddr_t ref_vaddr(input lsu_pkg::rob_id_t id);
    return sent_vaddr[id];
  endfunction

  // a load may finish only once its page is mapped and its line holds its tag
  function automatic logic model_hit(input lsu_pkg::vaddr_t addr);
    logic [LINE_W-1:0] line;
    line = addr[lsu_pkg::LINE_OFF_W +: LINE_W];
    return page_model[addr[lsu_pkg::PAGE_LSB +: lsu_pkg::PAGE_W]] && tag_valid_model[line] &&
           tag_model[line] == addr[TAG_LSB +: TAG_W];
  endfunction

  function automatic lsu_pkg::vaddr_t make_vaddr(input logic [TAG_W-1:0] tag,
                                                 input logic [LINE_W-1:0] line,
                                                 input logic [lsu_pkg::LINE_OFF_W-1:0] off);
    return {tag, line, off};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_rob_id(input string name, input lsu_pkg::rob_id_t got,
                              input lsu_pkg::rob_id_t exp);
    if (got !== exp)
      fail_run($sformatf("error: time %0t %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic check_vaddr(input string name, input lsu_pkg::vaddr_t got,
                             input lsu_pkg::vaddr_t exp);
    if (got !== exp)
      fail_run($sformatf("error: time %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("error: time %0t %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      fail_run($sformatf("error: time %0t %s got %0d expected %0d", $time, name, got, exp));
  endtask

  // ==================================================
  // monitor and watchdog
  // ==================================================
  // mid-cycle sample, outputs settled and inputs held for the next edge
  always @(negedge clk) begin
    if (!reset_n) begin
      credits       = LDQ_SIZE;
      credit_total  = 0;
      done_count    = 0;
      last_done_rob = '0;
      for (int i = 0; i < ROB_IDS; i++) rpt_cnt[i] = 0;
    end else begin
      check_flag("o_disp_credit", disp_credit, done_valid);  // one credit per report
      if (disp_valid) credits--;
      if (disp_credit) begin
        credits++;
        credit_total++;
      end
      if (credits < 0 || credits > LDQ_SIZE)
        fail_run($sformatf("outstanding loads out of range, %0d credits left", credits));
      if (done_valid) begin
        if (sent_cnt[done_rob_id] <= rpt_cnt[done_rob_id])
          fail_run($sformatf("report for ROB id %0d with no load outstanding", done_rob_id));
        check_vaddr("o_done_vaddr", done_vaddr, ref_vaddr(done_rob_id));
        if (!model_hit(done_vaddr))
          fail_run($sformatf("load at %h reported before its page and line were ready",
                             done_vaddr));
        rpt_cnt[done_rob_id]++;
        done_count++;
        last_done_rob = done_rob_id;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
      fail_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  // ==================================================
  // driver tasks
  // ==================================================
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      step();
      disp_valid = 1'b0;
    end
  endtask

  task automatic dispatch_load(input lsu_pkg::vaddr_t addr, output lsu_pkg::rob_id_t id);
    step();
    disp_valid = 1'b0;
    while (credits == 0) step();  // no credit, hold off
    id = lsu_pkg::rob_id_t'(next_rob % ROB_IDS);
    sent_vaddr[id] = addr;
    sent_cnt[id]++;
    next_rob++;
    disp_valid  = 1'b1;
    disp_rob_id = id;
    disp_vaddr  = addr;
  endtask

  task automatic refill_line(input lsu_pkg::vaddr_t addr);
    logic [LINE_W-1:0] line;
    line = addr[lsu_pkg::LINE_OFF_W +: LINE_W];
    step();
    disp_valid            = 1'b0;
    refill_valid          = 1'b1;
    refill_vaddr          = addr;
    tag_model[line]       = addr[TAG_LSB +: TAG_W];
    tag_valid_model[line] = 1'b1;
    step();
    refill_valid = 1'b0;
  endtask

  task automatic set_page(input int page, input logic val);
    step();
    disp_valid       = 1'b0;
    page_model[page] = val;
    tlb_page_valid   = page_model;
  endtask

  task automatic wait_done(input int target);
    while (done_count < target) begin
      step();
      disp_valid = 1'b0;
    end
  endtask

  initial begin
    lsu_pkg::rob_id_t  id;
    logic [31:0]       r;
    logic [TAG_W-1:0]  tag;
    int                base;
    int                credit_base;
    disp_valid      = 1'b0;
    disp_rob_id     = '0;
    disp_vaddr      = '0;
    refill_valid    = 1'b0;
    refill_vaddr    = '0;
    page_model      = '1;
    tlb_page_valid  = page_model;
    tag_valid_model = '0;
    next_rob        = 0;
    for (int i = 0; i < ROB_IDS; i++) sent_cnt[i] = 0;
    @(posedge reset_n);

    // idle queue stays quiet
    idle(20);
    check_count("done_count", done_count, 0);
    check_count("credit_total", credit_total, 0);

    // misses on line 2, woken by refills, other tag keeps waiting
    for (int i = 0; i < 4; i++) dispatch_load(lsu_pkg::vaddr_t'(16'h3020 + i), id);
    dispatch_load(16'h5024, id);
    idle(30);
    check_count("done_count", done_count, 0);
    refill_line(16'h3020);
    wait_done(4);
    idle(20);
    check_count("done_count", done_count, 4);
    refill_line(16'h5020);
    wait_done(5);
    check_rob_id("o_done_rob_id", last_done_rob, id);

    // random hits on pre-filled lines
    for (int l = 0; l < TAG_LINES; l++) begin
      r   = $random(seed);
      tag = '0;
      tag[7:0] = r[7:0];  // upper tag bits stay low, no clash with later tags
      refill_line(make_vaddr(tag, LINE_W'(l), '0));
    end
    base = done_count;
    for (int n = 0; n < 30; n++) begin
      r = $random(seed);
      dispatch_load(make_vaddr(tag_model[r[LINE_W-1:0]], r[LINE_W-1:0], r[7:4]), id);
    end
    wait_done(base + 30);

    // translation hazard on page 7
    set_page(7, 1'b0);
    refill_line(16'h7010);
    base = done_count;
    dispatch_load(16'h7018, id);
    idle(30);
    check_count("done_count", done_count, base);
    set_page(7, 1'b1);
    wait_done(base + 1);
    check_rob_id("o_done_rob_id", last_done_rob, id);

    // fill the queue with parked misses, credits run out
    base = done_count;
    for (int n = 0; n < LDQ_SIZE; n++)
      dispatch_load(lsu_pkg::vaddr_t'(16'h9000 + (n % TAG_LINES) * 16 + n / TAG_LINES), id);
    idle(20);
    check_count("credits", credits, 0);
    check_count("done_count", done_count, base);
    credit_base = credit_total;
    for (int l = 0; l < TAG_LINES; l++) refill_line(lsu_pkg::vaddr_t'(16'h9000 + l * 16));
    wait_done(base + LDQ_SIZE);
    check_count("returned credits", credit_total - credit_base, LDQ_SIZE);
    check_count("credits", credits, LDQ_SIZE);
    for (int n = 0; n < 4; n++) dispatch_load(lsu_pkg::vaddr_t'(16'h9004 + n * 16), id);
    wait_done(base + LDQ_SIZE + 4);
    idle(5);

    if (credits == LDQ_SIZE && done_count == next_rob) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_run($sformatf("end of run with %0d credits and %0d of %0d loads done",
                         credits, done_count, next_rob));
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/lsu_pkg.sv
rtl/ldq_pick.sv
rtl/ldq.sv
rtl/load_pipe.sv
rtl/lsu_top.sv
verif/tb_clkgen.sv
verif/lsu_asserts.sv
verif/tb_lsu.sv
